/* Makefile */
LOG = sim.log

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 -f issue_top.f --top-module issue_top_tb -Mdir obj_dir

run: compile
	./obj_dir/Vissue_top_tb | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* hdl/issue_buffer.sv */
`timescale 1ns/1ps

`include "issue_params.svh"

module issue_buffer (
    input  logic          clk,
    input  logic          rstn,
    pair_link_if.receiver in_link,
    pair_link_if.sender   out_link
);

    localparam int PTR_W = $clog2(`ISSUE_DEPTH);

    issue_pkg::issue_slot_t mem1 [`ISSUE_DEPTH];
    issue_pkg::issue_slot_t mem2 [`ISSUE_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [`CREDIT_W-1:0]   count;
    logic                   push;
    logic                   pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`ISSUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push           = in_link.valid;
    assign pop            = out_link.ret;

    assign out_link.valid = (count != '0);
    assign out_link.slot1 = mem1[rd_ptr];   // Head entry
    assign out_link.slot2 = mem2[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem1[wr_ptr] <= in_link.slot1;
            mem2[wr_ptr] <= in_link.slot2;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            in_link.ret <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count       <= count + `CREDIT_W'(push) - `CREDIT_W'(pop);
            in_link.ret <= pop;   // Credit back one cycle after the pop
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rstn)
        push |-> (count != `CREDIT_W'(`ISSUE_DEPTH))
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!rstn)
        pop |-> (count != '0)
    );

endmodule

/* hdl/issue_exe.sv */
`timescale 1ns/1ps

module issue_exe (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_stall_dcache,
    input  logic                i_stall_div,
    input  logic                i_flush_br,
    pair_link_if.receiver       link,
    output issue_pkg::reg_idx_t o_raddr1_1,
    output issue_pkg::reg_idx_t o_raddr1_2,
    output issue_pkg::reg_idx_t o_raddr2_1,
    output issue_pkg::reg_idx_t o_raddr2_2,
    input  issue_pkg::word_t    i_rdata1_1,
    input  issue_pkg::word_t    i_rdata1_2,
    input  issue_pkg::word_t    i_rdata2_1,
    input  issue_pkg::word_t    i_rdata2_2,
    output logic                o_a_valid,
    output issue_pkg::word_t    o_a_pc,
    output issue_pkg::word_t    o_a_pc_pre,
    output issue_pkg::word_t    o_a_rdata1,
    output issue_pkg::word_t    o_a_rdata2,
    output issue_pkg::word_t    o_a_imm,
    output issue_pkg::reg_idx_t o_a_rd,
    output logic                o_a_rf_we,
    output logic                o_a_br_pd,
    output logic                o_b_valid,
    output issue_pkg::word_t    o_b_pc,
    output issue_pkg::word_t    o_b_pc_pre,
    output issue_pkg::word_t    o_b_rdata1,
    output issue_pkg::word_t    o_b_rdata2,
    output issue_pkg::word_t    o_b_imm,
    output issue_pkg::reg_idx_t o_b_rd,
    output logic                o_b_rf_we,
    output logic                o_b_br_pd,
    output logic                o_b_mul_en,
    output logic                o_b_div_en
);

    logic                   stall;
    logic                   swap;
    logic                   valid_a;
    logic                   valid_b;
    issue_pkg::issue_slot_t slot_a;
    issue_pkg::issue_slot_t slot_b;

    assign stall    = i_stall_dcache | i_stall_div;
    assign link.ret = link.valid & ~stall;   // Flush still pops

    // Only lane B has the mul, div and branch hooks
    assign swap   = (link.slot1.cls != issue_pkg::IC_ALU);
    assign slot_a = swap ? link.slot2 : link.slot1;
    assign slot_b = swap ? link.slot1 : link.slot2;

    assign valid_a = link.valid & slot_a.valid & ~i_flush_br;
    assign valid_b = link.valid & slot_b.valid & ~i_flush_br;

    assign o_raddr1_1 = link.slot1.rs1;
    assign o_raddr1_2 = link.slot1.rs2;
    assign o_raddr2_1 = link.slot2.rs1;
    assign o_raddr2_2 = link.slot2.rs2;

    ////////////////////
    // Lane control
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_a_valid  <= 1'b0;
            o_b_valid  <= 1'b0;
            o_a_rf_we  <= 1'b0;
            o_b_rf_we  <= 1'b0;
            o_a_br_pd  <= 1'b0;
            o_b_br_pd  <= 1'b0;
            o_b_mul_en <= 1'b0;
            o_b_div_en <= 1'b0;
            o_a_pc_pre <= 32'd4;
            o_b_pc_pre <= 32'd4;
        end else if (!stall) begin
            o_a_valid  <= valid_a;
            o_b_valid  <= valid_b;
            o_a_rf_we  <= slot_a.rf_we & valid_a;
            o_b_rf_we  <= slot_b.rf_we & valid_b;
            o_a_br_pd  <= (slot_a.pc_pre != slot_a.pc + 32'd4);   // Predicted taken
            o_b_br_pd  <= (slot_b.pc_pre != slot_b.pc + 32'd4);
            o_b_mul_en <= valid_b & (slot_b.cls == issue_pkg::IC_MUL);
            o_b_div_en <= valid_b & (slot_b.cls == issue_pkg::IC_DIV);
            o_a_pc_pre <= valid_a ? slot_a.pc_pre : slot_a.pc + 32'd4;
            o_b_pc_pre <= valid_b ? slot_b.pc_pre : slot_b.pc + 32'd4;
        end
    end

    ////////////////////
    // Lane payload
    ////////////////////
    always_ff @(posedge clk) begin
        if (!stall) begin
            o_a_pc     <= slot_a.pc;
            o_b_pc     <= slot_b.pc;
            o_a_imm    <= slot_a.imm;
            o_b_imm    <= slot_b.imm;
            o_a_rd     <= slot_a.rd;
            o_b_rd     <= slot_b.rd;
            o_a_rdata1 <= swap ? i_rdata2_1 : i_rdata1_1;   // Operands follow the slot
            o_a_rdata2 <= swap ? i_rdata2_2 : i_rdata1_2;
            o_b_rdata1 <= swap ? i_rdata1_1 : i_rdata2_1;
            o_b_rdata2 <= swap ? i_rdata1_2 : i_rdata2_2;
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    // Lanes hold through a stall
    a_stall_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        stall |=> $stable({o_a_valid, o_b_valid, o_a_pc, o_b_pc, o_a_rf_we, o_b_rf_we})
    );

endmodule

/* hdl/issue_pkg.sv */
package issue_pkg;

    ////////////////////
    // Basic widths
    ////////////////////
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [1:0] {
        IC_ALU = 2'd0,
        IC_MUL = 2'd1,
        IC_DIV = 2'd2,
        IC_BR  = 2'd3
    } inst_class_t;

    ////////////////////
    // One decoded slot
    ////////////////////
    typedef struct packed {
        logic        valid;
        word_t       pc;
        word_t       pc_pre;      // Predicted next PC
        inst_class_t cls;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd;
        logic        rf_we;
        word_t       imm;
    } issue_slot_t;

endpackage

/* hdl/issue_top.sv */
`timescale 1ns/1ps

module issue_top (
    input  logic                clk,
    input  logic                rstn,
    input  logic                i_valid,
    input  logic                i_s1_valid,
    input  issue_pkg::word_t    i_s1_pc,
    input  issue_pkg::word_t    i_s1_pc_pre,
    input  logic [1:0]          i_s1_cls,
    input  issue_pkg::reg_idx_t i_s1_rs1,
    input  issue_pkg::reg_idx_t i_s1_rs2,
    input  issue_pkg::reg_idx_t i_s1_rd,
    input  logic                i_s1_rf_we,
    input  issue_pkg::word_t    i_s1_imm,
    input  logic                i_s2_valid,
    input  issue_pkg::word_t    i_s2_pc,
    input  issue_pkg::word_t    i_s2_pc_pre,
    input  logic [1:0]          i_s2_cls,
    input  issue_pkg::reg_idx_t i_s2_rs1,
    input  issue_pkg::reg_idx_t i_s2_rs2,
    input  issue_pkg::reg_idx_t i_s2_rd,
    input  logic                i_s2_rf_we,
    input  issue_pkg::word_t    i_s2_imm,
    output logic                o_ready,
    input  logic                i_stall_dcache,
    input  logic                i_stall_div,
    input  logic                i_flush_br,
    input  logic                i_wb_we_a,
    input  issue_pkg::reg_idx_t i_wb_waddr_a,
    input  issue_pkg::word_t    i_wb_wdata_a,
    input  logic                i_wb_we_b,
    input  issue_pkg::reg_idx_t i_wb_waddr_b,
    input  issue_pkg::word_t    i_wb_wdata_b,
    output logic                o_a_valid,
    output issue_pkg::word_t    o_a_pc,
    output issue_pkg::word_t    o_a_pc_pre,
    output issue_pkg::word_t    o_a_rdata1,
    output issue_pkg::word_t    o_a_rdata2,
    output issue_pkg::word_t    o_a_imm,
    output issue_pkg::reg_idx_t o_a_rd,
    output logic                o_a_rf_we,
    output logic                o_a_br_pd,
    output logic                o_b_valid,
    output issue_pkg::word_t    o_b_pc,
    output issue_pkg::word_t    o_b_pc_pre,
    output issue_pkg::word_t    o_b_rdata1,
    output issue_pkg::word_t    o_b_rdata2,
    output issue_pkg::word_t    o_b_imm,
    output issue_pkg::reg_idx_t o_b_rd,
    output logic                o_b_rf_we,
    output logic                o_b_br_pd,
    output logic                o_b_mul_en,
    output logic                o_b_div_en
);

    issue_pkg::issue_slot_t slot1;
    issue_pkg::issue_slot_t slot2;
    issue_pkg::reg_idx_t    raddr1_1;
    issue_pkg::reg_idx_t    raddr1_2;
    issue_pkg::reg_idx_t    raddr2_1;
    issue_pkg::reg_idx_t    raddr2_2;
    issue_pkg::word_t       rdata1_1;
    issue_pkg::word_t       rdata1_2;
    issue_pkg::word_t       rdata2_1;
    issue_pkg::word_t       rdata2_2;

    pair_link_if src_link ();
    pair_link_if pop_link ();

    ////////////////////
    // Pack the decode side
    ////////////////////
    assign slot1 = '{valid: i_s1_valid, pc: i_s1_pc, pc_pre: i_s1_pc_pre,
                     cls: issue_pkg::inst_class_t'(i_s1_cls), rs1: i_s1_rs1,
                     rs2: i_s1_rs2, rd: i_s1_rd, rf_we: i_s1_rf_we, imm: i_s1_imm};
    assign slot2 = '{valid: i_s2_valid, pc: i_s2_pc, pc_pre: i_s2_pc_pre,
                     cls: issue_pkg::inst_class_t'(i_s2_cls), rs1: i_s2_rs1,
                     rs2: i_s2_rs2, rd: i_s2_rd, rf_we: i_s2_rf_we, imm: i_s2_imm};

    pair_source pair_source_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_valid (i_valid),
        .i_slot1 (slot1),
        .i_slot2 (slot2),
        .o_ready (o_ready),
        .link    (src_link.sender)
    );

    issue_buffer issue_buffer_i (
        .clk      (clk),
        .rstn     (rstn),
        .in_link  (src_link.receiver),
        .out_link (pop_link.sender)
    );

    reg_file reg_file_i (
        .clk        (clk),
        .i_raddr1_1 (raddr1_1),
        .i_raddr1_2 (raddr1_2),
        .i_raddr2_1 (raddr2_1),
        .i_raddr2_2 (raddr2_2),
        .o_rdata1_1 (rdata1_1),
        .o_rdata1_2 (rdata1_2),
        .o_rdata2_1 (rdata2_1),
        .o_rdata2_2 (rdata2_2),
        .i_we_a     (i_wb_we_a),
        .i_waddr_a  (i_wb_waddr_a),
        .i_wdata_a  (i_wb_wdata_a),
        .i_we_b     (i_wb_we_b),
        .i_waddr_b  (i_wb_waddr_b),
        .i_wdata_b  (i_wb_wdata_b)
    );

    issue_exe issue_exe_i (
        .clk            (clk),
        .rstn           (rstn),
        .i_stall_dcache (i_stall_dcache),
        .i_stall_div    (i_stall_div),
        .i_flush_br     (i_flush_br),
        .link           (pop_link.receiver),
        .o_raddr1_1     (raddr1_1),
        .o_raddr1_2     (raddr1_2),
        .o_raddr2_1     (raddr2_1),
        .o_raddr2_2     (raddr2_2),
        .i_rdata1_1     (rdata1_1),
        .i_rdata1_2     (rdata1_2),
        .i_rdata2_1     (rdata2_1),
        .i_rdata2_2     (rdata2_2),
        .o_a_valid      (o_a_valid),
        .o_a_pc         (o_a_pc),
        .o_a_pc_pre     (o_a_pc_pre),
        .o_a_rdata1     (o_a_rdata1),
        .o_a_rdata2     (o_a_rdata2),
        .o_a_imm        (o_a_imm),
        .o_a_rd         (o_a_rd),
        .o_a_rf_we      (o_a_rf_we),
        .o_a_br_pd      (o_a_br_pd),
        .o_b_valid      (o_b_valid),
        .o_b_pc         (o_b_pc),
        .o_b_pc_pre     (o_b_pc_pre),
        .o_b_rdata1     (o_b_rdata1),
        .o_b_rdata2     (o_b_rdata2),
        .o_b_imm        (o_b_imm),
        .o_b_rd         (o_b_rd),
        .o_b_rf_we      (o_b_rf_we),
        .o_b_br_pd      (o_b_br_pd),
        .o_b_mul_en     (o_b_mul_en),
        .o_b_div_en     (o_b_div_en)
    );

endmodule

/* hdl/pair_link_if.sv */
`timescale 1ns/1ps

interface pair_link_if;

    logic                   valid;   // Push or not-empty, depending on the link
    issue_pkg::issue_slot_t slot1;
    issue_pkg::issue_slot_t slot2;
    logic                   ret;     // Credit return or pop

    modport sender (
        output valid,
        output slot1,
        output slot2,
        input  ret
    );

    modport receiver (
        input  valid,
        input  slot1,
        input  slot2,
        output ret
    );

endinterface

/* hdl/pair_source.sv */
`timescale 1ns/1ps

`include "issue_params.svh"

module pair_source (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   i_valid,
    input  issue_pkg::issue_slot_t i_slot1,
    input  issue_pkg::issue_slot_t i_slot2,
    output logic                   o_ready,
    pair_link_if.sender            link
);

    logic [`CREDIT_W-1:0] credit_cnt;
    logic                 push;

    assign o_ready    = (credit_cnt != '0);
    assign push       = i_valid & o_ready;   // Spend a credit per pair

    assign link.valid = push;
    assign link.slot1 = i_slot1;
    assign link.slot2 = i_slot2;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credit_cnt <= `CREDIT_W'(`ISSUE_DEPTH);
        end else begin
            credit_cnt <= credit_cnt - `CREDIT_W'(push) + `CREDIT_W'(link.ret);
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    // A wrap below zero also lands above the depth
    a_credit_range: assert property (
        @(posedge clk) disable iff (!rstn)
        credit_cnt <= `CREDIT_W'(`ISSUE_DEPTH)
    );

    // The buffer only returns credits that were spent
    a_credit_return: assert property (
        @(posedge clk) disable iff (!rstn)
        link.ret |-> (credit_cnt < `CREDIT_W'(`ISSUE_DEPTH))
    );

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

`include "issue_params.svh"

module reg_file (
    input  logic                clk,
    input  issue_pkg::reg_idx_t i_raddr1_1,
    input  issue_pkg::reg_idx_t i_raddr1_2,
    input  issue_pkg::reg_idx_t i_raddr2_1,
    input  issue_pkg::reg_idx_t i_raddr2_2,
    output issue_pkg::word_t    o_rdata1_1,
    output issue_pkg::word_t    o_rdata1_2,
    output issue_pkg::word_t    o_rdata2_1,
    output issue_pkg::word_t    o_rdata2_2,
    input  logic                i_we_a,
    input  issue_pkg::reg_idx_t i_waddr_a,
    input  issue_pkg::word_t    i_wdata_a,
    input  logic                i_we_b,
    input  issue_pkg::reg_idx_t i_waddr_b,
    input  issue_pkg::word_t    i_wdata_b
);

    issue_pkg::word_t regs [`NUM_REGS];

    function automatic issue_pkg::word_t rd_reg(input issue_pkg::reg_idx_t addr);
        return (addr == '0) ? '0 : regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (i_we_a && (i_waddr_a != '0)) begin
            regs[i_waddr_a] <= i_wdata_a;
        end
        if (i_we_b && (i_waddr_b != '0)) begin
            regs[i_waddr_b] <= i_wdata_b;   // Port b wins
        end
    end

    assign o_rdata1_1 = rd_reg(i_raddr1_1);
    assign o_rdata1_2 = rd_reg(i_raddr1_2);
    assign o_rdata2_1 = rd_reg(i_raddr2_1);
    assign o_rdata2_2 = rd_reg(i_raddr2_2);

endmodule

/* include/issue_params.svh */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

////////////////////
// Issue buffer
////////////////////
`define ISSUE_DEPTH 4   // Entries, also the initial credit count
`define CREDIT_W    3   // Credit and occupancy counters

////////////////////
// Register file
////////////////////
`define NUM_REGS    32

`endif

/* issue_top.f */
+incdir+include
hdl/issue_pkg.sv
hdl/pair_link_if.sv
hdl/pair_source.sv
hdl/issue_buffer.sv
hdl/reg_file.sv
hdl/issue_exe.sv
hdl/issue_top.sv
tb/issue_top_tb.sv

/* tb/issue_tests.txt */
# W port addr data | P slot1 slot2: valid pc pc_pre cls rs1 rs2 rd rf_we imm | S cycles | F | R ready
# E lane A: valid pc pc_pre rdata1 rdata2 imm rd rf_we br_pd, lane B: same plus mul_en div_en
W 0 01 11111111
W 0 02 22222222
W 1 03 33333333
W 1 04 44444444
W 0 05 55555555
# ALU first slot keeps order, r0 reads zero
P 1 100 104 0 01 02 0a 1 10
  1 104 108 0 03 00 0b 1 20
E 1 100 104 11111111 22222222 10 0a 1 0
  1 104 108 33333333 00000000 20 0b 1 0 0 0
# MUL swaps
P 1 200 204 1 04 05 0c 1 30
  1 204 208 0 01 03 0d 0 40
E 1 204 208 11111111 33333333 40 0d 0 0
  1 200 204 44444444 55555555 30 0c 1 0 1 0
# DIV swaps
P 1 300 304 2 02 02 0e 1 50
  1 304 308 0 00 05 0f 1 60
E 1 304 308 00000000 55555555 60 0f 1 0
  1 300 304 22222222 22222222 50 0e 1 0 0 1
# Taken branch swaps
P 1 400 480 3 01 04 00 0 70
  1 404 408 0 02 03 10 1 80
E 1 404 408 22222222 33333333 80 10 1 0
  1 400 480 11111111 44444444 70 00 0 1 0 0
# Predicted taken on lane A, invalid slot2
P 1 500 540 0 03 04 11 1 90
  0 504 508 0 01 01 12 1 a0
E 1 500 540 33333333 44444444 90 11 1 1
  0 504 508 11111111 11111111 a0 12 0 0 0 0
# Long stall, four pairs fill the buffer
S 28
P 1 600 604 0 01 02 01 1 6
  1 604 608 0 03 04 02 1 66
P 1 700 704 0 01 02 01 1 7
  1 704 708 0 03 04 02 1 77
P 1 800 804 0 01 02 01 1 8
  1 804 808 0 03 04 02 1 88
P 1 900 904 0 01 02 01 1 9
  1 904 908 0 03 04 02 1 99
R 0
P 1 a00 a04 0 01 02 01 1 a
  1 a04 a08 0 03 04 02 1 aa
E 1 600 604 11111111 22222222 6 01 1 0
  1 604 608 33333333 44444444 66 02 1 0 0 0
E 1 700 704 11111111 22222222 7 01 1 0
  1 704 708 33333333 44444444 77 02 1 0 0 0
E 1 800 804 11111111 22222222 8 01 1 0
  1 804 808 33333333 44444444 88 02 1 0 0 0
E 1 900 904 11111111 22222222 9 01 1 0
  1 904 908 33333333 44444444 99 02 1 0 0 0
E 1 a00 a04 11111111 22222222 a 01 1 0
  1 a04 a08 33333333 44444444 aa 02 1 0 0 0
# Flushed pair vanishes, next one issues
F
P 1 b00 b04 0 01 02 03 1 b
  1 b04 b08 1 03 04 04 1 bb
P 1 c00 c04 0 05 01 05 1 c
  1 c04 c08 0 02 00 06 1 cc
E 1 c00 c04 55555555 11111111 c 05 1 0
  1 c04 c08 22222222 00000000 cc 06 1 0 0 0

/* tb/issue_top_tb.sv */
`timescale 1ns/1ps

module issue_top_tb;

    typedef struct packed {
        logic                valid;
        issue_pkg::word_t    pc;
        issue_pkg::word_t    pc_pre;
        issue_pkg::word_t    rdata1;
        issue_pkg::word_t    rdata2;
        issue_pkg::word_t    imm;
        issue_pkg::reg_idx_t rd;
        logic                rf_we;
        logic                br_pd;
        logic                mul_en;
        logic                div_en;
    } lane_t;

    logic clk;
    logic rstn;
    logic i_valid;
    logic i_s1_valid, i_s1_rf_we, i_s2_valid, i_s2_rf_we;
    issue_pkg::word_t i_s1_pc, i_s1_pc_pre, i_s1_imm, i_s2_pc, i_s2_pc_pre, i_s2_imm;
    logic [1:0] i_s1_cls, i_s2_cls;
    issue_pkg::reg_idx_t i_s1_rs1, i_s1_rs2, i_s1_rd, i_s2_rs1, i_s2_rs2, i_s2_rd;
    logic o_ready;
    logic i_stall_dcache, i_stall_div, i_flush_br;
    logic i_wb_we_a, i_wb_we_b;
    issue_pkg::reg_idx_t i_wb_waddr_a, i_wb_waddr_b;
    issue_pkg::word_t i_wb_wdata_a, i_wb_wdata_b;
    logic o_a_valid, o_a_rf_we, o_a_br_pd, o_b_valid, o_b_rf_we, o_b_br_pd;
    logic o_b_mul_en, o_b_div_en;
    issue_pkg::word_t o_a_pc, o_a_pc_pre, o_a_rdata1, o_a_rdata2, o_a_imm;
    issue_pkg::word_t o_b_pc, o_b_pc_pre, o_b_rdata1, o_b_rdata2, o_b_imm;
    issue_pkg::reg_idx_t o_a_rd, o_b_rd;

    int    errors = 0;
    int    checks = 0;
    int    fd;
    bit    flush_next = 0;
    bit    edge_stall = 0;
    bit    have_prev = 0;
    lane_t prev_a, prev_b;
    lane_t obs_a [$];
    lane_t obs_b [$];

    issue_top issue_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Compare tasks
    ////////////////////
    task automatic check_word(input string name, input issue_pkg::word_t exp,
                              input issue_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_idx(input string name, input issue_pkg::reg_idx_t exp,
                             input issue_pkg::reg_idx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic compare_lane(input string ln, input bit hooks, input lane_t exp,
                                input lane_t act);
        check_bit({"o_", ln, "_valid"}, exp.valid, act.valid);
        check_word({"o_", ln, "_pc"}, exp.pc, act.pc);
        check_word({"o_", ln, "_pc_pre"}, exp.pc_pre, act.pc_pre);
        check_word({"o_", ln, "_rdata1"}, exp.rdata1, act.rdata1);
        check_word({"o_", ln, "_rdata2"}, exp.rdata2, act.rdata2);
        check_word({"o_", ln, "_imm"}, exp.imm, act.imm);
        check_idx({"o_", ln, "_rd"}, exp.rd, act.rd);
        check_bit({"o_", ln, "_rf_we"}, exp.rf_we, act.rf_we);
        check_bit({"o_", ln, "_br_pd"}, exp.br_pd, act.br_pd);
        if (hooks) begin
            check_bit({"o_", ln, "_mul_en"}, exp.mul_en, act.mul_en);
            check_bit({"o_", ln, "_div_en"}, exp.div_en, act.div_en);
        end
    endtask

    ////////////////////
    // Output monitor
    ////////////////////
    always @(posedge clk) begin
        edge_stall = i_stall_dcache | i_stall_div;   // Value the DUT saw at this edge
    end

    always @(negedge clk) begin
        lane_t a;
        lane_t b;
        a = '{o_a_valid, o_a_pc, o_a_pc_pre, o_a_rdata1, o_a_rdata2, o_a_imm, o_a_rd,
              o_a_rf_we, o_a_br_pd, 1'b0, 1'b0};
        b = '{o_b_valid, o_b_pc, o_b_pc_pre, o_b_rdata1, o_b_rdata2, o_b_imm, o_b_rd,
              o_b_rf_we, o_b_br_pd, o_b_mul_en, o_b_div_en};
        if (rstn) begin
            if (edge_stall && have_prev) begin
                compare_lane("a", 1'b0, prev_a, a);   // Frozen lanes
                compare_lane("b", 1'b1, prev_b, b);
            end else if (!edge_stall && (a.valid || b.valid)) begin
                obs_a.push_back(a);
                obs_b.push_back(b);
            end
            if (!a.valid) check_bit("o_a_rf_we", 1'b0, a.rf_we);
            if (!b.valid) check_bit("o_b_rf_we", 1'b0, b.rf_we);
            prev_a    = a;
            prev_b    = b;
            have_prev = 1;
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////
    task automatic read_slot(output issue_pkg::issue_slot_t s);
        logic [31:0] v [9];
        int          n;
        n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
        if (n != 9) begin
            errors++;
            $display("Malformed slot record in the tests file");
        end
        s = '{v[0][0], v[1], v[2], issue_pkg::inst_class_t'(v[3][1:0]), v[4][4:0],
              v[5][4:0], v[6][4:0], v[7][0], v[8]};
    endtask

    task automatic read_lane(input bit hooks, output lane_t l);
        logic [31:0] v [11];
        int          n;
        v[9]  = '0;
        v[10] = '0;
        n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
        if (hooks) n += $fscanf(fd, " %h %h", v[9], v[10]);
        if (n != (hooks ? 11 : 9)) begin
            errors++;
            $display("Malformed expected-value record in the tests file");
        end
        l = '{v[0][0], v[1], v[2], v[3], v[4], v[5], v[6][4:0], v[7][0], v[8][0],
              v[9][0], v[10][0]};
    endtask

    task automatic write_reg(input logic port, input issue_pkg::reg_idx_t addr,
                             input issue_pkg::word_t data);
        @(posedge clk);
        i_wb_we_a    <= !port;
        i_wb_we_b    <= port;
        i_wb_waddr_a <= addr;
        i_wb_waddr_b <= addr;
        i_wb_wdata_a <= data;
        i_wb_wdata_b <= data;
        @(posedge clk);
        i_wb_we_a <= 1'b0;
        i_wb_we_b <= 1'b0;
    endtask

    task automatic offer_pair(input issue_pkg::issue_slot_t s1, input issue_pkg::issue_slot_t s2);
        int n;
        @(posedge clk);
        i_valid     <= 1'b1;
        i_s1_valid  <= s1.valid;
        i_s1_pc     <= s1.pc;
        i_s1_pc_pre <= s1.pc_pre;
        i_s1_cls    <= s1.cls;
        i_s1_rs1    <= s1.rs1;
        i_s1_rs2    <= s1.rs2;
        i_s1_rd     <= s1.rd;
        i_s1_rf_we  <= s1.rf_we;
        i_s1_imm    <= s1.imm;
        i_s2_valid  <= s2.valid;
        i_s2_pc     <= s2.pc;
        i_s2_pc_pre <= s2.pc_pre;
        i_s2_cls    <= s2.cls;
        i_s2_rs1    <= s2.rs1;
        i_s2_rs2    <= s2.rs2;
        i_s2_rd     <= s2.rd;
        i_s2_rf_we  <= s2.rf_we;
        i_s2_imm    <= s2.imm;
        n = 0;
        @(negedge clk);
        while (!o_ready && n < 200) begin
            n++;
            @(negedge clk);
        end
        if (!o_ready) begin
            errors++;
            $display("Timed out waiting for o_ready to accept pair at pc %h", s1.pc);
        end
        @(posedge clk);   // Acceptance edge
        i_valid <= 1'b0;
        if (flush_next) begin
            i_flush_br <= 1'b1;   // Lands on the pop of this pair
            @(posedge clk);
            i_flush_br <= 1'b0;
            flush_next = 0;
        end
    endtask

    task automatic hold_stall(input int cycles);
        fork
            begin
                @(posedge clk);
                i_stall_dcache <= 1'b1;
                repeat (cycles) @(posedge clk);
                i_stall_dcache <= 1'b0;
            end
        join_none
    endtask

    task automatic expect_pair(input lane_t ea, input lane_t eb);
        int n;
        n = 0;
        while (obs_a.size() == 0 && n < 200) begin
            n++;
            @(negedge clk);
        end
        if (obs_a.size() == 0) begin
            errors++;
            $display("Timed out waiting for a valid lane output at pc %h", ea.pc);
        end else begin
            compare_lane("a", 1'b0, ea, obs_a.pop_front());
            compare_lane("b", 1'b1, eb, obs_b.pop_front());
        end
    endtask

    initial begin
        logic [8*16-1:0]        cmd;
        logic [8*128-1:0]       line;
        logic [31:0]            p0, p1, p2;
        issue_pkg::issue_slot_t s1, s2;
        lane_t                  ea, eb;
        int                     n;
        {i_valid, i_s1_valid, i_s1_rf_we, i_s2_valid, i_s2_rf_we} = '0;
        {i_s1_pc, i_s1_pc_pre, i_s1_imm, i_s2_pc, i_s2_pc_pre, i_s2_imm} = '0;
        {i_s1_cls, i_s2_cls} = '0;
        {i_s1_rs1, i_s1_rs2, i_s1_rd, i_s2_rs1, i_s2_rs2, i_s2_rd} = '0;
        {i_stall_dcache, i_stall_div, i_flush_br, i_wb_we_a, i_wb_we_b} = '0;
        {i_wb_waddr_a, i_wb_waddr_b, i_wb_wdata_a, i_wb_wdata_b} = '0;
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);

        // Reset state
        check_bit("o_ready", 1'b1, o_ready);
        check_bit("o_a_valid", 1'b0, o_a_valid);
        check_bit("o_b_valid", 1'b0, o_b_valid);
        check_bit("o_a_rf_we", 1'b0, o_a_rf_we);
        check_bit("o_b_rf_we", 1'b0, o_b_rf_we);
        check_bit("o_b_mul_en", 1'b0, o_b_mul_en);
        check_bit("o_b_div_en", 1'b0, o_b_div_en);
        check_bit("o_a_br_pd", 1'b0, o_a_br_pd);
        check_bit("o_b_br_pd", 1'b0, o_b_br_pd);
        check_word("o_a_pc_pre", 32'd4, o_a_pc_pre);
        check_word("o_b_pc_pre", 32'd4, o_b_pc_pre);

        fd = $fopen("tb/issue_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open tb/issue_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, " %s", cmd);
                if (n != 1) break;
                if (cmd == "#") begin
                    n = $fgets(line, fd);
                end else if (cmd == "W") begin
                    n = $fscanf(fd, " %h %h %h", p0, p1, p2);
                    write_reg(p0[0], p1[4:0], p2);
                end else if (cmd == "P") begin
                    read_slot(s1);
                    read_slot(s2);
                    offer_pair(s1, s2);
                end else if (cmd == "S") begin
                    n = $fscanf(fd, " %h", p0);
                    hold_stall(int'(p0));
                end else if (cmd == "F") begin
                    flush_next = 1;
                end else if (cmd == "R") begin
                    n = $fscanf(fd, " %h", p0);
                    @(negedge clk);
                    check_bit("o_ready", p0[0], o_ready);
                end else if (cmd == "E") begin
                    read_lane(1'b0, ea);
                    read_lane(1'b1, eb);
                    expect_pair(ea, eb);
                end else begin
                    errors++;
                    $display("Unknown command %0s in the tests file", cmd);
                end
            end
            $fclose(fd);
        end

        repeat (8) @(posedge clk);   // Let any stray issue show up
        if (obs_a.size() != 0) begin
            errors++;
            $display("%0d lane outputs appeared that no record expected", obs_a.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
